// File: accel_pkg.sv
package accel_pkg;

    // array rows and columns, also operands per packed word
    localparam int LANES = 4;

    typedef logic signed [7:0]  byte_t;
    typedef logic [31:0]        word_t;
    typedef logic signed [31:0] acc_t;
    typedef logic [15:0]        addr_t;
    typedef logic [15:0]        dim_t;

    // ----------------------------------------
    // controller states
    // ----------------------------------------

    // operand feeder
    typedef enum logic [2:0] {
        feed_idle,
        feed_fetch,
        feed_stream,
        feed_drain,
        feed_finish
    } feed_state_t;

    // result writer
    typedef enum logic [1:0] {
        wr_idle,
        wr_send,
        wr_release
    } write_state_t;

endpackage

// File: pe_cell.sv
`timescale 1ns/1ns

module pe_cell (
    input  logic             clk,
    input  logic             rst_n,
    input  accel_pkg::byte_t a_in,
    input  accel_pkg::byte_t b_in,
    input  logic             first_in,
    input  logic             last_in,
    output accel_pkg::byte_t a_out,
    output accel_pkg::byte_t b_out,
    output logic             first_out,
    output logic             last_out,
    output accel_pkg::acc_t  sum,
    output logic             capture
);

    accel_pkg::acc_t prod;

    // sign extended to full accumulator width
    assign prod = a_in * b_in;

    // tags travel with the operands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            first_out <= 1'b0;
            last_out  <= 1'b0;
            capture   <= 1'b0;
        end else begin
            first_out <= first_in;
            last_out  <= last_in;
            capture   <= last_in;
        end
    end

    always_ff @(posedge clk) begin
        a_out <= a_in;
        b_out <= b_in;
        // first k of a tile restarts the sum
        if (first_in) begin
            sum <= prod;
        end else begin
            sum <= sum + prod;
        end
    end

endmodule

// File: systolic_array.sv
`timescale 1ns/1ns

module systolic_array (
    input  logic             clk,
    input  logic             rst_n,
    input  accel_pkg::byte_t row_op [accel_pkg::LANES],
    input  accel_pkg::byte_t col_op [accel_pkg::LANES],
    input  logic             op_first,
    input  logic             op_last,
    input  accel_pkg::dim_t  tile_row_in,
    input  accel_pkg::dim_t  tile_col_in,
    output logic             tile_req,
    input  logic             tile_ack,
    output accel_pkg::acc_t  tile_data [accel_pkg::LANES*accel_pkg::LANES],
    output accel_pkg::dim_t  tile_row,
    output accel_pkg::dim_t  tile_col,
    output logic             bank_busy
);

    accel_pkg::byte_t row_in [accel_pkg::LANES];
    accel_pkg::byte_t col_in [accel_pkg::LANES];

    accel_pkg::byte_t a_i [accel_pkg::LANES][accel_pkg::LANES];
    accel_pkg::byte_t b_i [accel_pkg::LANES][accel_pkg::LANES];
    logic             first_i [accel_pkg::LANES][accel_pkg::LANES];
    logic             last_i [accel_pkg::LANES][accel_pkg::LANES];

    accel_pkg::byte_t a_q [accel_pkg::LANES][accel_pkg::LANES];
    accel_pkg::byte_t b_q [accel_pkg::LANES][accel_pkg::LANES];
    logic             first_q [accel_pkg::LANES][accel_pkg::LANES];
    logic             last_q [accel_pkg::LANES][accel_pkg::LANES];
    accel_pkg::acc_t  sum_q [accel_pkg::LANES][accel_pkg::LANES];
    logic             cap_q [accel_pkg::LANES][accel_pkg::LANES];

    // ----------------------------------------
    // input skew, lane i delayed by i cycles
    // ----------------------------------------
    for (genvar i = 0; i < accel_pkg::LANES; i++) begin : g_skew
        if (i == 0) begin : g_direct
            assign row_in[i] = row_op[i];
            assign col_in[i] = col_op[i];
        end else begin : g_delay
            accel_pkg::byte_t row_d [i];
            accel_pkg::byte_t col_d [i];

            always_ff @(posedge clk) begin
                row_d[0] <= row_op[i];
                col_d[0] <= col_op[i];
                for (int s = 1; s < i; s++) begin
                    row_d[s] <= row_d[s-1];
                    col_d[s] <= col_d[s-1];
                end
            end

            assign row_in[i] = row_d[i-1];
            assign col_in[i] = col_d[i-1];
        end
    end

    // ----------------------------------------
    // PE grid
    // ----------------------------------------
    for (genvar r = 0; r < accel_pkg::LANES; r++) begin : g_row
        for (genvar c = 0; c < accel_pkg::LANES; c++) begin : g_col
            // tags go down column 0, then along each row
            if (c == 0) begin : g_west
                assign a_i[r][c] = row_in[r];
                if (r == 0) begin : g_corner
                    assign first_i[r][c] = op_first;
                    assign last_i[r][c]  = op_last;
                end else begin : g_edge
                    assign first_i[r][c] = first_q[r-1][c];
                    assign last_i[r][c]  = last_q[r-1][c];
                end
            end else begin : g_inner
                assign a_i[r][c]     = a_q[r][c-1];
                assign first_i[r][c] = first_q[r][c-1];
                assign last_i[r][c]  = last_q[r][c-1];
            end

            if (r == 0) begin : g_north
                assign b_i[r][c] = col_in[c];
            end else begin : g_south
                assign b_i[r][c] = b_q[r-1][c];
            end

            pe_cell u_pe (
                .clk       (clk),
                .rst_n     (rst_n),
                .a_in      (a_i[r][c]),
                .b_in      (b_i[r][c]),
                .first_in  (first_i[r][c]),
                .last_in   (last_i[r][c]),
                .a_out     (a_q[r][c]),
                .b_out     (b_q[r][c]),
                .first_out (first_q[r][c]),
                .last_out  (last_q[r][c]),
                .sum       (sum_q[r][c]),
                .capture   (cap_q[r][c])
            );
        end
    end

    // diagonal capture, each PE on its own cycle
    always_ff @(posedge clk) begin
        for (int r = 0; r < accel_pkg::LANES; r++) begin
            for (int c = 0; c < accel_pkg::LANES; c++) begin
                if (cap_q[r][c]) begin
                    tile_data[r*accel_pkg::LANES+c] <= sum_q[r][c];
                end
            end
        end
        if (op_last) begin
            tile_row <= tile_row_in;
            tile_col <= tile_col_in;
        end
    end

    // ----------------------------------------
    // hand-off to the writer
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tile_req  <= 1'b0;
            bank_busy <= 1'b0;
        end else begin
            // bank is claimed as soon as the last k enters
            if (op_last) begin
                bank_busy <= 1'b1;
            end else if (tile_req && tile_ack) begin
                bank_busy <= 1'b0;
            end

            if (cap_q[accel_pkg::LANES-1][accel_pkg::LANES-1]) begin
                tile_req <= 1'b1;
            end else if (tile_ack) begin
                tile_req <= 1'b0;
            end
        end
    end

endmodule

// File: operand_feeder.sv
`timescale 1ns/1ns

module operand_feeder (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_req,
    input  accel_pkg::dim_t  m_dim,
    input  accel_pkg::dim_t  n_dim,
    input  accel_pkg::dim_t  k_words,
    output accel_pkg::addr_t a_addr,
    output accel_pkg::addr_t b_addr,
    input  accel_pkg::word_t a_rdata,
    input  accel_pkg::word_t b_rdata,
    output accel_pkg::byte_t row_op [accel_pkg::LANES],
    output accel_pkg::byte_t col_op [accel_pkg::LANES],
    output logic             op_first,
    output logic             op_last,
    output accel_pkg::dim_t  tile_row_in,
    output accel_pkg::dim_t  tile_col_in,
    input  logic             bank_busy,
    output logic             feed_done
);

    accel_pkg::feed_state_t state;
    accel_pkg::dim_t        step;
    accel_pkg::dim_t        last_step;
    accel_pkg::dim_t        word_idx;
    logic [1:0]             lane;
    logic                   streaming;

    // lanes 0..2 wait here until lane 3 arrives
    accel_pkg::word_t a_hold [accel_pkg::LANES-1];
    accel_pkg::word_t b_hold [accel_pkg::LANES-1];
    accel_pkg::word_t a_sreg [accel_pkg::LANES];
    accel_pkg::word_t b_sreg [accel_pkg::LANES];

    assign last_step = {k_words[13:0], 2'b00};
    assign streaming = (state == accel_pkg::feed_stream);
    assign lane      = step[1:0];
    assign feed_done = (state == accel_pkg::feed_finish);

    // ----------------------------------------
    // addresses, one lane per cycle
    // ----------------------------------------
    // fetch primes word 0, stream runs one word ahead
    assign word_idx = streaming ? (step >> 2) + 16'd1 : '0;
    assign a_addr   = (tile_row_in + lane) * k_words + word_idx;
    assign b_addr   = (tile_col_in + lane) * k_words + word_idx;

    assign op_first = streaming && (step == 16'd1);
    assign op_last  = streaming && (step == last_step);

    for (genvar i = 0; i < accel_pkg::LANES; i++) begin : g_lane
        assign row_op[i] = a_sreg[i][7:0];
        assign col_op[i] = b_sreg[i][7:0];
    end

    // ----------------------------------------
    // operand registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if ((state == accel_pkg::feed_fetch || streaming) && lane != 2'd0) begin
            a_hold[lane - 2'd1] <= a_rdata;
            b_hold[lane - 2'd1] <= b_rdata;
        end
        if (streaming) begin
            if (lane == 2'd0 && step != last_step) begin
                for (int i = 0; i < accel_pkg::LANES - 1; i++) begin
                    a_sreg[i] <= a_hold[i];
                    b_sreg[i] <= b_hold[i];
                end
                a_sreg[accel_pkg::LANES-1] <= a_rdata;
                b_sreg[accel_pkg::LANES-1] <= b_rdata;
            end else begin
                for (int i = 0; i < accel_pkg::LANES; i++) begin
                    a_sreg[i] <= a_sreg[i] >> 8;
                    b_sreg[i] <= b_sreg[i] >> 8;
                end
            end
        end
    end

    // ----------------------------------------
    // tile walk
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= accel_pkg::feed_idle;
            step        <= '0;
            tile_row_in <= '0;
            tile_col_in <= '0;
        end else begin
            step <= step + 16'd1;
            case (state)
                accel_pkg::feed_idle: begin
                    step <= '0;
                    if (start_req) begin
                        tile_row_in <= '0;
                        tile_col_in <= '0;
                        state       <= accel_pkg::feed_fetch;
                    end
                end
                accel_pkg::feed_fetch: begin
                    if (lane == 2'd3) begin
                        step  <= '0;
                        state <= accel_pkg::feed_stream;
                    end
                end
                accel_pkg::feed_stream: begin
                    if (step == last_step) begin
                        state <= accel_pkg::feed_drain;
                    end
                end
                accel_pkg::feed_drain: begin
                    step <= '0;
                    // wait for the writer to take the tile
                    if (!bank_busy) begin
                        if (tile_col_in + 16'd4 < n_dim) begin
                            tile_col_in <= tile_col_in + 16'd4;
                            state       <= accel_pkg::feed_fetch;
                        end else if (tile_row_in + 16'd4 < m_dim) begin
                            tile_row_in <= tile_row_in + 16'd4;
                            tile_col_in <= '0;
                            state       <= accel_pkg::feed_fetch;
                        end else begin
                            state <= accel_pkg::feed_finish;
                        end
                    end
                end
                accel_pkg::feed_finish: begin
                    if (!start_req) begin
                        state <= accel_pkg::feed_idle;
                    end
                end
                default: begin
                    state <= accel_pkg::feed_idle;
                end
            endcase
        end
    end

endmodule

// File: result_writer.sv
`timescale 1ns/1ns

module result_writer #(
    parameter accel_pkg::addr_t OUT_BASE = 16'd0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             tile_req,
    output logic             tile_ack,
    input  accel_pkg::acc_t  tile_data [accel_pkg::LANES*accel_pkg::LANES],
    input  accel_pkg::dim_t  tile_row,
    input  accel_pkg::dim_t  tile_col,
    input  accel_pkg::dim_t  n_dim,
    input  logic             feed_done,
    input  logic             start_req,
    output logic             start_ack,
    output logic             out_wen,
    output accel_pkg::addr_t out_addr,
    output accel_pkg::acc_t  out_wdata
);

    accel_pkg::write_state_t state;
    logic [3:0]              idx;
    logic                    take;

    accel_pkg::acc_t store [accel_pkg::LANES*accel_pkg::LANES];
    accel_pkg::dim_t row_base;
    accel_pkg::dim_t col_base;

    assign take = (state == accel_pkg::wr_idle) && tile_req && !tile_ack;

    // tile copy and write data
    always_ff @(posedge clk) begin
        if (take) begin
            store    <= tile_data;
            row_base <= tile_row;
            col_base <= tile_col;
        end
        if (state == accel_pkg::wr_send) begin
            out_wdata <= store[idx];
            // row-major, idx[3:2] is the row within the tile
            out_addr  <= OUT_BASE + (row_base + idx[3:2]) * n_dim + col_base + idx[1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= accel_pkg::wr_idle;
            idx       <= '0;
            tile_ack  <= 1'b0;
            start_ack <= 1'b0;
            out_wen   <= 1'b0;
        end else begin
            out_wen <= 1'b0;

            if (tile_ack && !tile_req) begin
                tile_ack <= 1'b0;
            end

            // job ends once nothing is left to write
            if (!start_ack && feed_done && state == accel_pkg::wr_idle && !tile_req) begin
                start_ack <= 1'b1;
            end else if (start_ack && !start_req) begin
                start_ack <= 1'b0;
            end

            case (state)
                accel_pkg::wr_idle: begin
                    if (take) begin
                        tile_ack <= 1'b1;
                        idx      <= '0;
                        state    <= accel_pkg::wr_send;
                    end
                end
                accel_pkg::wr_send: begin
                    out_wen <= 1'b1;
                    idx     <= idx + 4'd1;
                    if (idx == 4'd15) begin
                        state <= accel_pkg::wr_release;
                    end
                end
                accel_pkg::wr_release: begin
                    if (!tile_ack) begin
                        state <= accel_pkg::wr_idle;
                    end
                end
                default: begin
                    state <= accel_pkg::wr_idle;
                end
            endcase
        end
    end

endmodule

// File: matmul_top.sv
`timescale 1ns/1ns

module matmul_top #(
    parameter accel_pkg::addr_t OUT_BASE = 16'd512
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_req,
    output logic             start_ack,
    input  accel_pkg::dim_t  m_dim,
    input  accel_pkg::dim_t  n_dim,
    input  accel_pkg::dim_t  k_words,
    output accel_pkg::addr_t a_addr,
    input  accel_pkg::word_t a_rdata,
    output accel_pkg::addr_t b_addr,
    input  accel_pkg::word_t b_rdata,
    output logic             out_wen,
    output accel_pkg::addr_t out_addr,
    output accel_pkg::acc_t  out_wdata
);

    accel_pkg::byte_t row_op [accel_pkg::LANES];
    accel_pkg::byte_t col_op [accel_pkg::LANES];
    logic             op_first;
    logic             op_last;
    accel_pkg::dim_t  tile_row_in;
    accel_pkg::dim_t  tile_col_in;
    logic             bank_busy;
    logic             feed_done;

    logic             tile_req;
    logic             tile_ack;
    accel_pkg::acc_t  tile_data [accel_pkg::LANES*accel_pkg::LANES];
    accel_pkg::dim_t  tile_row;
    accel_pkg::dim_t  tile_col;

    operand_feeder u_operand_feeder (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_req   (start_req),
        .m_dim       (m_dim),
        .n_dim       (n_dim),
        .k_words     (k_words),
        .a_addr      (a_addr),
        .b_addr      (b_addr),
        .a_rdata     (a_rdata),
        .b_rdata     (b_rdata),
        .row_op      (row_op),
        .col_op      (col_op),
        .op_first    (op_first),
        .op_last     (op_last),
        .tile_row_in (tile_row_in),
        .tile_col_in (tile_col_in),
        .bank_busy   (bank_busy),
        .feed_done   (feed_done)
    );

    systolic_array u_systolic_array (
        .clk         (clk),
        .rst_n       (rst_n),
        .row_op      (row_op),
        .col_op      (col_op),
        .op_first    (op_first),
        .op_last     (op_last),
        .tile_row_in (tile_row_in),
        .tile_col_in (tile_col_in),
        .tile_req    (tile_req),
        .tile_ack    (tile_ack),
        .tile_data   (tile_data),
        .tile_row    (tile_row),
        .tile_col    (tile_col),
        .bank_busy   (bank_busy)
    );

    result_writer #(
        .OUT_BASE (OUT_BASE)
    ) u_result_writer (
        .clk       (clk),
        .rst_n     (rst_n),
        .tile_req  (tile_req),
        .tile_ack  (tile_ack),
        .tile_data (tile_data),
        .tile_row  (tile_row),
        .tile_col  (tile_col),
        .n_dim     (n_dim),
        .feed_done (feed_done),
        .start_req (start_req),
        .start_ack (start_ack),
        .out_wen   (out_wen),
        .out_addr  (out_addr),
        .out_wdata (out_wdata)
    );

endmodule

// File: tb_checker.sv
`timescale 1ns/1ns

module tb_checker #(
    parameter accel_pkg::addr_t OUT_BASE = 16'd0
) (
    input logic             clk,
    input logic             rst_n,
    input logic             start_req,
    input logic             start_ack,
    input logic             out_wen,
    input accel_pkg::addr_t out_addr,
    input accel_pkg::acc_t  out_wdata
);

    localparam int MAX_ENTRIES = 256;

    accel_pkg::acc_t expected [MAX_ENTRIES];
    int              hits [MAX_ENTRIES];
    string           test_name = "none";
    int              job_size = 0;
    int              job_n = 1;
    int              writes = 0;
    logic            job_active = 1'b0;
    logic            ack_q = 1'b0;
    logic            reset_seen = 1'b0;
    int              error_count = 0;
    int              check_count = 0;

    task automatic begin_job(input string name, input int m, input int n);
        test_name  = name;
        job_n      = n;
        job_size   = m * n;
        writes     = 0;
        job_active = 1'b1;
        for (int i = 0; i < MAX_ENTRIES; i++) begin
            hits[i] = 0;
        end
    endtask

    task automatic set_expected(input int idx, input accel_pkg::acc_t value);
        expected[idx] = value;
    endtask

    // every entry of the job written once
    task automatic end_job();
        for (int i = 0; i < job_size; i++) begin
            if (hits[i] == 0) begin
                error_count++;
                $display("%s: no write to address %0d", test_name, int'(OUT_BASE) + i);
            end
        end
        job_active = 1'b0;
    endtask

    task automatic check_write();
        int offset;
        offset = int'(out_addr) - int'(OUT_BASE);
        if (!job_active || offset < 0 || offset >= job_size) begin
            error_count++;
            $display("%s: write to address %0d outside the output range", test_name, out_addr);
        end else if (hits[offset] != 0) begin
            error_count++;
            $display("%s: second write to address %0d", test_name, out_addr);
        end else begin
            hits[offset] = 1;
            writes++;
            check_count++;
            if (out_wdata !== expected[offset]) begin
                error_count++;
                $display("FAIL %s C[%0d][%0d]: expected %0d, actual %0d", test_name,
                         offset / job_n, offset % job_n, expected[offset], out_wdata);
            end
        end
    endtask

    // ----------------------------------------
    // output port monitor
    // ----------------------------------------
    always @(negedge clk) begin
        if (!rst_n) begin
            ack_q = 1'b0;
        end else begin
            if (!reset_seen) begin
                reset_seen = 1'b1;
                if (start_ack || out_wen) begin
                    error_count++;
                    $display("start_ack or out_wen high right after reset");
                end
            end
            // ack may only rise once the whole job is out
            if (start_ack && !ack_q && (!job_active || writes != job_size)) begin
                error_count++;
                $display("%s: start_ack rose after %0d of %0d writes", test_name, writes,
                         job_size);
            end
            if (out_wen) begin
                check_write();
            end
            if (!start_ack && ack_q && start_req) begin
                error_count++;
                $display("%s: start_ack fell while start_req was still high", test_name);
            end
            ack_q = start_ack;
        end
    end

endmodule

// File: tb_matmul.sv
`timescale 1ns/1ns

module tb_matmul;

    localparam accel_pkg::addr_t OUT_BASE = 16'd512;
    localparam int NUM_JOBS  = 8;
    localparam int MEM_WORDS = 256;

    logic             clk;
    logic             rst_n;
    logic             start_req;
    logic             start_ack;
    accel_pkg::dim_t  m_dim;
    accel_pkg::dim_t  n_dim;
    accel_pkg::dim_t  k_words;
    accel_pkg::addr_t a_addr;
    accel_pkg::addr_t b_addr;
    accel_pkg::word_t a_rdata;
    accel_pkg::word_t b_rdata;
    logic             out_wen;
    accel_pkg::addr_t out_addr;
    accel_pkg::acc_t  out_wdata;

    accel_pkg::word_t a_mem [MEM_WORDS];
    accel_pkg::word_t b_mem [MEM_WORDS];

    logic [31:0] rng;
    int          job_m [NUM_JOBS];
    int          job_n [NUM_JOBS];
    int          job_k [NUM_JOBS];
    int          cycles = 0;
    int          cycle_limit = 0;

    matmul_top #(
        .OUT_BASE (OUT_BASE)
    ) u_matmul_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_req (start_req),
        .start_ack (start_ack),
        .m_dim     (m_dim),
        .n_dim     (n_dim),
        .k_words   (k_words),
        .a_addr    (a_addr),
        .a_rdata   (a_rdata),
        .b_addr    (b_addr),
        .b_rdata   (b_rdata),
        .out_wen   (out_wen),
        .out_addr  (out_addr),
        .out_wdata (out_wdata)
    );

    tb_checker #(
        .OUT_BASE (OUT_BASE)
    ) u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_req (start_req),
        .start_ack (start_ack),
        .out_wen   (out_wen),
        .out_addr  (out_addr),
        .out_wdata (out_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // one-cycle read latency and zero outside the model
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_rdata <= '0;
            b_rdata <= '0;
        end else begin
            a_rdata <= (a_addr < MEM_WORDS) ? a_mem[a_addr] : '0;
            b_rdata <= (b_addr < MEM_WORDS) ? b_mem[b_addr] : '0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT did not finish its jobs", cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic string job_name(input int j);
        if (j == 0) begin
            return "single_tile";
        end else if (j == 1) begin
            return "extreme_values";
        end
        return "random_job";
    endfunction

    // ----------------------------------------
    // job list and reference model
    // ----------------------------------------
    task automatic pick_jobs();
        cycle_limit = 200;
        for (int j = 0; j < NUM_JOBS; j++) begin
            if (j == 0) begin
                job_m[j] = 4;
                job_n[j] = 4;
                job_k[j] = 1;
            end else if (j == 1) begin
                job_m[j] = 8;
                job_n[j] = 8;
                job_k[j] = 8;
            end else begin
                rng = xorshift(rng);
                job_m[j] = 4 * (1 + int'(rng % 32'd4));
                rng = xorshift(rng);
                job_n[j] = 4 * (1 + int'(rng % 32'd4));
                rng = xorshift(rng);
                job_k[j] = 1 + int'(rng % 32'd8);
            end
            cycle_limit += (job_m[j] / 4) * (job_n[j] / 4) * (4 * job_k[j] + 40);
        end
    endtask

    task automatic fill_memories(input int j);
        for (int w = 0; w < MEM_WORDS; w++) begin
            if (j == 1) begin
                a_mem[w] = 32'h8080_8080;
                // +127 in even columns and -128 in odd ones
                b_mem[w] = ((w / job_k[j]) % 2 == 0) ? 32'h7f7f_7f7f : 32'h8080_8080;
            end else begin
                rng = xorshift(rng);
                a_mem[w] = rng;
                rng = xorshift(rng);
                b_mem[w] = rng;
            end
        end
    endtask

    // byte 0 of a word is the lowest k
    function automatic int dot_entry(input int row, input int col, input int kw_n);
        int               acc;
        logic [31:0]      aw;
        logic [31:0]      bw;
        logic signed [7:0] ab;
        logic signed [7:0] bb;
        acc = 0;
        for (int kw = 0; kw < kw_n; kw++) begin
            aw = a_mem[row * kw_n + kw];
            bw = b_mem[col * kw_n + kw];
            for (int b = 0; b < 4; b++) begin
                ab = aw[8*b +: 8];
                bb = bw[8*b +: 8];
                acc = acc + int'(ab) * int'(bb);
            end
        end
        return acc;
    endfunction

    task automatic run_job(input int j);
        fill_memories(j);
        u_checker.begin_job(job_name(j), job_m[j], job_n[j]);
        for (int i = 0; i < job_m[j]; i++) begin
            for (int c = 0; c < job_n[j]; c++) begin
                u_checker.set_expected(i * job_n[j] + c, dot_entry(i, c, job_k[j]));
            end
        end
        @(posedge clk);
        #1;
        m_dim     = accel_pkg::dim_t'(job_m[j]);
        n_dim     = accel_pkg::dim_t'(job_n[j]);
        k_words   = accel_pkg::dim_t'(job_k[j]);
        start_req = 1'b1;
        @(posedge clk);
        #1;
        while (!start_ack) begin
            @(posedge clk);
            #1;
        end
        start_req = 1'b0;
        while (start_ack) begin
            @(posedge clk);
            #1;
        end
        u_checker.end_job();
    endtask

    initial begin
        rst_n     = 1'b0;
        start_req = 1'b0;
        m_dim     = '0;
        n_dim     = '0;
        k_words   = '0;
        rng       = 32'h027b_e891;
        pick_jobs();
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // jobs run back to back
        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(j);
        end
        repeat (8) @(posedge clk);
        $display("checks: %0d, errors: %0d", u_checker.check_count, u_checker.error_count);
        if (u_checker.error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: flist.f
accel_pkg.sv
pe_cell.sv
systolic_array.sv
operand_feeder.sv
result_writer.sv
matmul_top.sv
tb_checker.sv
tb_matmul.sv

// File: Makefile
TOP = tb_matmul

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f flist.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
